// ==== hw/vec_issue_pkg.sv ====
//////////////////////////////////////////////////
// Vector issue front end package
// Opcode constants, field positions and the record
// carried from issue to dispatch
//////////////////////////////////////////////////

package vec_issue_pkg;

  // Raw instruction word as offered by the core
  typedef logic [31:0] insn_t;

  // Buffered instruction with its scalar writeback flag
  typedef struct packed {
    insn_t instr;
    logic  writeback;
  } vec_insn_t;

  // Instruction field positions
  localparam int unsigned OpcodeLsb = 0;
  localparam int unsigned OpcodeMsb = 6;
  localparam int unsigned Funct3Lsb = 12;
  localparam int unsigned Funct3Msb = 14;
  localparam int unsigned Funct6Lsb = 26;
  localparam int unsigned Funct6Msb = 31;

  // Major opcodes
  localparam logic [6:0] OpcodeOpV     = 7'b101_0111;
  localparam logic [6:0] OpcodeLoadFp  = 7'b000_0111;
  localparam logic [6:0] OpcodeStoreFp = 7'b010_0111;

  // OP-V funct3 categories
  localparam logic [2:0] Funct3OpFvv = 3'b001;
  localparam logic [2:0] Funct3OpMvv = 3'b010;
  localparam logic [2:0] Funct3OpCfg = 3'b111;

  // Unary group with vmv.x.s, vfmv.f.s and vcpop
  localparam logic [5:0] Funct6WxUnary0 = 6'b01_0000;

  // Width codes that mark a LOAD-FP/STORE-FP as vector
  localparam logic [2:0] MemWidthVec8  = 3'b000;
  localparam logic [2:0] MemWidthVec16 = 3'b101;
  localparam logic [2:0] MemWidthVec32 = 3'b110;
  localparam logic [2:0] MemWidthVec64 = 3'b111;

  localparam int unsigned DefaultFifoDepth = 4;

endpackage : vec_issue_pkg

// ==== hw/vec_issue_decoder.sv ====
//////////////////////////////////////////////////
// Light-weight issue decoder
// Decides vector accept and scalar writeback
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_issue_decoder import vec_issue_pkg::*; (
  input  insn_t instr_i,
  output logic  accept_o,
  output logic  writeback_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic       is_opv;
  logic       is_fp_mem;
  logic       vec_width;

  // Field extraction
  assign opcode = instr_i[OpcodeMsb:OpcodeLsb];
  assign funct3 = instr_i[Funct3Msb:Funct3Lsb];
  assign funct6 = instr_i[Funct6Msb:Funct6Lsb];

  assign is_opv    = (opcode == OpcodeOpV);
  assign is_fp_mem = (opcode == OpcodeLoadFp) || (opcode == OpcodeStoreFp);

  // Scalar FP loads and stores use the remaining width codes
  always_comb begin
    unique case (funct3)
      MemWidthVec8,
      MemWidthVec16,
      MemWidthVec32,
      MemWidthVec64: vec_width = 1'b1;
      default:       vec_width = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Accept and writeback
  //////////////////////////////////////////////////

  always_comb begin
    accept_o    = 1'b0;
    writeback_o = 1'b0;

    if (is_opv) begin
      accept_o = 1'b1;
      // vsetvl family returns the new vl
      if (funct3 == Funct3OpCfg) begin
        writeback_o = 1'b1;
      end
      // Moves to x/f registers and vcpop return a scalar
      if (((funct3 == Funct3OpMvv) || (funct3 == Funct3OpFvv)) &&
          (funct6 == Funct6WxUnary0)) begin
        writeback_o = 1'b1;
      end
    end else if (is_fp_mem && vec_width) begin
      accept_o = 1'b1;
    end
  end

endmodule : vec_issue_decoder

// ==== hw/vec_issue_stage.sv ====
//////////////////////////////////////////////////
// Issue stage
// Issue ready and one-entry pre-buffer before FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_issue_stage import vec_issue_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Issue channel
  input  logic      issue_valid_i,
  input  insn_t     issue_instr_i,
  output logic      issue_ready_o,
  // Decode of the offered instruction
  input  logic      accept_i,
  input  logic      writeback_i,
  // Flushes
  input  logic      flush_i,
  input  logic      flush_unissued_i,
  // FIFO side
  input  logic      fifo_full_i,
  output logic      fifo_push_o,
  output vec_insn_t fifo_wdata_o
);

  logic      new_instr;
  logic      load_entry;
  logic      entry_full_d;
  logic      entry_full_q;
  vec_insn_t entry_q;

  // No issue while the FIFO is full or being flushed
  assign issue_ready_o = issue_valid_i && !fifo_full_i && !flush_i;

  // Rejected handshakes complete without entering the buffer
  assign new_instr = issue_valid_i && issue_ready_o && accept_i;

  //////////////////////////////////////////////////
  // Pre-buffer control
  //////////////////////////////////////////////////

  always_comb begin
    fifo_push_o  = 1'b0;
    load_entry   = 1'b0;
    entry_full_d = entry_full_q;

    // Drain into the FIFO whenever it has room
    if (!fifo_full_i && entry_full_q) begin
      fifo_push_o  = 1'b1;
      entry_full_d = 1'b0;
    end

    // Same-cycle reload keeps one instruction per cycle
    if (!fifo_full_i && new_instr) begin
      load_entry   = 1'b1;
      entry_full_d = 1'b1;
    end

    if (flush_unissued_i) begin
      fifo_push_o  = 1'b0;
      entry_full_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entry_full_q <= 1'b0;
    end else begin
      entry_full_q <= entry_full_d;
    end
  end

  // Pre-buffer payload
  always_ff @(posedge clk_i) begin
    if (load_entry) begin
      entry_q.instr     <= issue_instr_i;
      entry_q.writeback <= writeback_i;
    end
  end

  assign fifo_wdata_o = entry_q;

endmodule : vec_issue_stage

// ==== hw/vec_insn_fifo.sv ====
//////////////////////////////////////////////////
// Instruction FIFO
// Flushable circular buffer with fill count
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_insn_fifo import vec_issue_pkg::*; #(
  parameter  int unsigned Depth      = DefaultFifoDepth,
  localparam int unsigned UsageWidth = $clog2(Depth + 1)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  // Write side
  input  logic                  push_i,
  input  vec_insn_t             wdata_i,
  output logic                  full_o,
  // Read side
  input  logic                  pop_i,
  output vec_insn_t             rdata_o,
  output logic                  empty_o,
  output logic [UsageWidth-1:0] usage_o
);

  // At least one pointer bit even for a single entry
  localparam int unsigned AddrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [AddrWidth-1:0]  LastAddr  = AddrWidth'(Depth - 1);
  localparam logic [UsageWidth-1:0] FullCount = UsageWidth'(Depth);

  vec_insn_t             mem_q [Depth];
  logic [AddrWidth-1:0]  wr_ptr_q;
  logic [AddrWidth-1:0]  rd_ptr_q;
  logic [UsageWidth-1:0] count_q;
  logic                  push_ok;
  logic                  pop_ok;

  assign full_o  = (count_q == FullCount);
  assign empty_o = (count_q == '0);
  assign usage_o = count_q;
  assign rdata_o = mem_q[rd_ptr_q];

  // Overflow and underflow are ignored
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  //////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == LastAddr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == LastAddr) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule : vec_insn_fifo

// ==== hw/vec_issue_frontend.sv ====
//////////////////////////////////////////////////
// Vector issue front end
// Decoder, pre-buffer and instruction FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_issue_frontend import vec_issue_pkg::*; #(
  parameter  int unsigned Depth      = DefaultFifoDepth,
  localparam int unsigned UsageWidth = $clog2(Depth + 1)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Issue channel from the core
  input  logic                  issue_valid_i,
  input  insn_t                 issue_instr_i,
  output logic                  issue_ready_o,
  output logic                  issue_accept_o,
  output logic                  issue_writeback_o,
  // Flushes
  input  logic                  flush_i,
  input  logic                  flush_unissued_i,
  // Dispatch port
  output logic                  disp_valid_o,
  input  logic                  disp_ready_i,
  output vec_insn_t             disp_instr_o,
  output logic [UsageWidth-1:0] usage_o
);

  logic      fifo_push;
  logic      fifo_full;
  logic      fifo_empty;
  logic      fifo_pop;
  vec_insn_t fifo_wdata;

  vec_issue_decoder u_vec_issue_decoder (
    .instr_i     (issue_instr_i    ),
    .accept_o    (issue_accept_o   ),
    .writeback_o (issue_writeback_o)
  );

  vec_issue_stage u_vec_issue_stage (
    .clk_i            (clk_i            ),
    .rst_ni           (rst_ni           ),
    .issue_valid_i    (issue_valid_i    ),
    .issue_instr_i    (issue_instr_i    ),
    .issue_ready_o    (issue_ready_o    ),
    .accept_i         (issue_accept_o   ),
    .writeback_i      (issue_writeback_o),
    .flush_i          (flush_i          ),
    .flush_unissued_i (flush_unissued_i ),
    .fifo_full_i      (fifo_full        ),
    .fifo_push_o      (fifo_push        ),
    .fifo_wdata_o     (fifo_wdata       )
  );

  // Dispatch handshake on the FIFO head
  assign disp_valid_o = !fifo_empty;
  assign fifo_pop     = disp_ready_i && !fifo_empty;

  vec_insn_fifo #(
    .Depth (Depth)
  ) u_vec_insn_fifo (
    .clk_i   (clk_i       ),
    .rst_ni  (rst_ni      ),
    .flush_i (flush_i     ),
    .push_i  (fifo_push   ),
    .wdata_i (fifo_wdata  ),
    .full_o  (fifo_full   ),
    .pop_i   (fifo_pop    ),
    .rdata_o (disp_instr_o),
    .empty_o (fifo_empty  ),
    .usage_o (usage_o     )
  );

endmodule : vec_issue_frontend

// ==== tb/tb_clk_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock and reset generator
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule : tb_clk_gen

// ==== tb/vec_issue_frontend_assert.sv ====
//////////////////////////////////////////////////
// Port assertions for the vector issue front end
//////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_issue_frontend_assert import vec_issue_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      issue_valid_i,
  input logic      issue_ready_o,
  input logic      flush_i,
  input logic      disp_valid_o,
  input logic      disp_ready_i,
  input vec_insn_t disp_instr_o
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ready_o |-> issue_valid_i)
    else begin
      $error("issue_ready_o high without issue_valid_i");
      fail_cnt++;
    end

  no_ready_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> !issue_ready_o)
    else begin
      $error("issue_ready_o high during flush_i");
      fail_cnt++;
    end

  // FIFO is empty right after a flush
  empty_after_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !disp_valid_o)
    else begin
      $error("disp_valid_o high in the cycle after flush_i");
      fail_cnt++;
    end

  head_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (disp_valid_o && !disp_ready_i && !flush_i) |=> $stable(disp_instr_o))
    else begin
      $error("disp_instr_o changed while the head was stalled");
      fail_cnt++;
    end

endmodule : vec_issue_frontend_assert

// ==== tb/tb_vec_issue_frontend.sv ====
//////////////////////////////////////////////////
// Testbench for the vector issue front end
// File driven issues, reference queue and watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_vec_issue_frontend import vec_issue_pkg::*; ();

  localparam int unsigned Depth      = DefaultFifoDepth;
  localparam int unsigned UsageWidth = $clog2(Depth + 1);

  logic                  clk;
  logic                  rst_n;
  logic                  issue_valid;
  insn_t                 issue_instr;
  logic                  issue_ready;
  logic                  issue_accept;
  logic                  issue_writeback;
  logic                  flush;
  logic                  flush_unissued;
  logic                  disp_valid;
  logic                  disp_ready;
  vec_insn_t             disp_instr;
  logic [UsageWidth-1:0] usage;

  // Stimulus lines and the expected dispatch order
  byte         cmd_q[$];
  insn_t       word_q[$];
  logic        acc_q[$];
  logic        wb_q[$];
  int          accept_idx[$];
  vec_insn_t   ref_q[$];
  logic [31:0] lfsr_state;
  logic        load_done;

  tb_clk_gen #(.PeriodNs(8), .ResetCycles(5)) u_tb_clk_gen (.clk_o(clk), .rst_no(rst_n));

  vec_issue_frontend #(
    .Depth (Depth)
  ) u_vec_issue_frontend (
    .clk_i             (clk            ),
    .rst_ni            (rst_n          ),
    .issue_valid_i     (issue_valid    ),
    .issue_instr_i     (issue_instr    ),
    .issue_ready_o     (issue_ready    ),
    .issue_accept_o    (issue_accept   ),
    .issue_writeback_o (issue_writeback),
    .flush_i           (flush          ),
    .flush_unissued_i  (flush_unissued ),
    .disp_valid_o      (disp_valid     ),
    .disp_ready_i      (disp_ready     ),
    .disp_instr_o      (disp_instr     ),
    .usage_o           (usage          )
  );

  bind vec_issue_frontend vec_issue_frontend_assert u_vec_issue_frontend_assert (
    .clk_i         (clk_i        ),
    .rst_ni        (rst_ni       ),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .flush_i       (flush_i      ),
    .disp_valid_o  (disp_valid_o ),
    .disp_ready_i  (disp_ready_i ),
    .disp_instr_o  (disp_instr_o )
  );

  //////////////////////////////////////////////////
  // Error reporting and checks
  //////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_decode(input logic acc, input logic wb, input logic exp_acc,
                              input logic exp_wb, input insn_t instr);
    if (acc !== exp_acc) begin
      report_error($sformatf("Error: issue_accept_o = %h, expected %h for instr %h",
                             acc, exp_acc, instr));
    end
    if (wb !== exp_wb) begin
      report_error($sformatf("Error: issue_writeback_o = %h, expected %h for instr %h",
                             wb, exp_wb, instr));
    end
  endtask

  task automatic check_dispatch(input vec_insn_t got, input vec_insn_t exp);
    if (got !== exp) begin
      report_error($sformatf("Error: disp_instr_o = %h, expected %h", got, exp));
    end
  endtask

  task automatic check_usage(input logic [UsageWidth-1:0] got,
                             input logic [UsageWidth-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("Error: usage_o = %h, expected %h", got, exp));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_random_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  //////////////////////////////////////////////////
  // Cycle driver and command tasks
  //////////////////////////////////////////////////

  // Drive on the falling edge, sample while outputs are settled
  task automatic run_cycle(input logic valid, input insn_t instr, input logic ready,
                           input logic do_flush, output logic hs);
    @(negedge clk);
    issue_valid    = valid;
    issue_instr    = instr;
    disp_ready     = ready;
    flush          = do_flush;
    flush_unissued = do_flush;
    #1;
    if (disp_valid && disp_ready) begin
      if (ref_q.size() == 0) begin
        report_error("Dispatch port offered an instruction that was never accepted");
      end
      check_dispatch(disp_instr, ref_q.pop_front());
    end
    hs = valid && issue_ready;
  endtask

  task automatic issue_entry(input int idx, input logic random_ready);
    logic      hs;
    logic      rdy;
    vec_insn_t exp;
    hs = 1'b0;
    while (!hs) begin
      rdy = 1'b0;
      if (random_ready) begin
        take_random_bit(rdy);
      end
      run_cycle(1'b1, word_q[idx], rdy, 1'b0, hs);
    end
    check_decode(issue_accept, issue_writeback, acc_q[idx], wb_q[idx], word_q[idx]);
    if (acc_q[idx]) begin
      exp.instr     = word_q[idx];
      exp.writeback = wb_q[idx];
      ref_q.push_back(exp);
    end
  endtask

  task automatic drain_all();
    logic hs;
    while (ref_q.size() != 0) begin
      run_cycle(1'b0, '0, 1'b1, 1'b0, hs);
    end
    run_cycle(1'b0, '0, 1'b1, 1'b0, hs);
    check_usage(usage, '0);
  endtask

  task automatic flush_frontend();
    logic hs;
    run_cycle(1'b0, '0, 1'b0, 1'b1, hs);
    ref_q.delete();
    repeat (2) begin
      run_cycle(1'b0, '0, 1'b0, 1'b0, hs);
      check_usage(usage, '0);
      if (disp_valid !== 1'b0) begin
        report_error("Error: disp_valid_o = 1 after flush, expected 0");
      end
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    byte         c;
    logic [31:0] word;
    logic [31:0] acc;
    logic [31:0] wb;
    fd = $fopen("tb/issue_input.txt", "r");
    if (fd == 0) begin
      report_error("Cannot open the stimulus file tb/issue_input.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0) continue;
      c = line.getc(0);
      if (c == "/" || c == "\n" || c == "\r" || c == " ") continue;
      if (c == "I") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", word, acc, wb);
        if (n != 3) begin
          report_error($sformatf("Malformed issue line in stimulus file: %s", line));
        end
        if (acc[0]) accept_idx.push_back(cmd_q.size());
      end else if (c == "F" || c == "D") begin
        word = '0;
        acc  = '0;
        wb   = '0;
      end else begin
        report_error($sformatf("Unknown command in stimulus file: %s", line));
      end
      cmd_q.push_back(c);
      word_q.push_back(word);
      acc_q.push_back(acc[0]);
      wb_q.push_back(wb[0]);
    end
    $fclose(fd);
    if (accept_idx.size() == 0) begin
      report_error("Stimulus file holds no accepted instruction");
    end
  endtask

  //////////////////////////////////////////////////
  // Test phases
  //////////////////////////////////////////////////

  task automatic run_latency_test();
    int   cycles;
    logic hs;
    issue_entry(accept_idx[0], 1'b0);
    cycles = 0;
    do begin
      run_cycle(1'b0, '0, 1'b0, 1'b0, hs);
      cycles++;
    end while (!disp_valid && cycles < 8);
    if (cycles != 2) begin
      report_error($sformatf("Error: disp_valid_o latency = %h cycles, expected %h", cycles, 2));
    end
    drain_all();
  endtask

  task automatic run_backpressure_test();
    int   taken;
    int   stalled;
    int   idx;
    logic hs;
    vec_insn_t exp;
    taken   = 0;
    stalled = 0;
    while (stalled < 4) begin
      idx = accept_idx[taken % accept_idx.size()];
      run_cycle(1'b1, word_q[idx], 1'b0, 1'b0, hs);
      if (hs) begin
        check_decode(issue_accept, issue_writeback, acc_q[idx], wb_q[idx], word_q[idx]);
        exp.instr     = word_q[idx];
        exp.writeback = wb_q[idx];
        ref_q.push_back(exp);
        taken++;
        stalled = 0;
      end else begin
        stalled++;
      end
    end
    if (taken != Depth + 1) begin
      report_error($sformatf("Error: accepted handshakes = %h, expected %h", taken, Depth + 1));
    end
    check_usage(usage, UsageWidth'(Depth));
    drain_all();
  endtask

  task automatic run_file_commands();
    for (int i = 0; i < cmd_q.size(); i++) begin
      case (cmd_q[i])
        "I":     issue_entry(i, 1'b1);
        "F":     flush_frontend();
        default: drain_all();
      endcase
    end
    drain_all();
  endtask

  initial begin
    issue_valid    = 1'b0;
    issue_instr    = '0;
    flush          = 1'b0;
    flush_unissued = 1'b0;
    disp_ready     = 1'b0;
    lfsr_state     = 32'h5fa0_148e;
    load_done      = 1'b0;
    load_stimulus();
    load_done = 1'b1;
    wait (rst_n === 1'b1);
    drain_all();
    if (disp_valid !== 1'b0) begin
      report_error($sformatf("Error: disp_valid_o = %h after reset, expected 0", disp_valid));
    end
    run_latency_test();
    run_backpressure_test();
    run_file_commands();
    if (u_vec_issue_frontend.u_vec_issue_frontend_assert.fail_cnt != 0) begin
      report_error("Bound assertions on the front end ports failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

  // Watchdog scaled to the number of stimulus lines
  initial begin
    int limit;
    wait (load_done === 1'b1);
    limit = 40 * cmd_q.size() + 100;
    repeat (limit) @(posedge clk);
    report_error($sformatf("Watchdog expired after %0d cycles, the run did not finish", limit));
  end

endmodule : tb_vec_issue_frontend

// ==== tb/issue_input.txt ====
// Columns: command, instruction word in hex, expected accept, expected writeback
// I issues a word, F flushes for one cycle, D drains the dispatch port
I 022180D7 1 0
I 010572D7 1 1
I 00510093 0 0
I 424023D7 1 1
I 02056087 1 0
I 00052087 0 0
D
I 428824D7 1 1
I 422010D7 1 1
I 9621A0D7 1 0
I 021190D7 1 0
I 4021C0D7 1 0
I 4202E157 1 0
I 020581A7 1 0
F
I 803170D7 1 1
I 0025B427 0 0
I 02065207 1 0
D
I 0206F2A7 1 0
I 00053087 0 0
I 00012083 0 0
I 022180D7 1 0
I 424023D7 1 1
I 02056087 1 0
I 010572D7 1 1
I 020581A7 1 0
I 9621A0D7 1 0
F
I 422010D7 1 1
I 02065207 1 0
I 4202E157 1 0
I 803170D7 1 1
D

// ==== filelist.f ====
hw/vec_issue_pkg.sv
hw/vec_issue_decoder.sv
hw/vec_issue_stage.sv
hw/vec_insn_fifo.sv
hw/vec_issue_frontend.sv
tb/tb_clk_gen.sv
tb/vec_issue_frontend_assert.sv
tb/tb_vec_issue_frontend.sv
